/* hw/exec_pkg.sv */
// shared constants, opcodes and stream payload types for the integer execute cluster
`default_nettype none

package exec_pkg;

  // datapath and cluster sizing
  localparam int unsigned xlen       = 32;
  localparam int unsigned num_lanes  = 4;
  localparam int unsigned lane_idx_w = $clog2(num_lanes);
  localparam int unsigned reg_addr_w = 5;

  // low bits of rs2 used as shift amount
  localparam int unsigned shamt_w = $clog2(xlen);

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_sll  = 4'd5,
    op_srl  = 4'd6,
    op_sra  = 4'd7,
    op_slt  = 4'd8,
    op_sltu = 4'd9
  } alu_op_e;

  // decoded op with operands already read
  typedef struct packed {
    alu_op_e                op;
    logic [xlen-1:0]        rs1_val;
    logic [xlen-1:0]        rs2_val;
    logic [reg_addr_w-1:0]  rd;
  } alu_req_t;

  // register writeback
  typedef struct packed {
    logic [reg_addr_w-1:0]  rd;
    logic [xlen-1:0]        result;
  } wb_t;

  // round-robin step, wraps after the last lane
  function automatic logic [lane_idx_w-1:0] next_lane(input logic [lane_idx_w-1:0] ptr);
    logic [lane_idx_w-1:0] nxt;
    if (ptr == lane_idx_w'(num_lanes - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

endpackage

`default_nettype wire

/* hw/alu_dispatcher.sv */
// routes the incoming ALU request stream round-robin onto the lanes, one lane at a time
`timescale 1ns/1ps
`default_nettype none

module alu_dispatcher (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush,

  input  logic                              in_valid,
  input  exec_pkg::alu_req_t                in_req,
  output logic                              in_ready,

  output logic [exec_pkg::num_lanes-1:0]    lane_valid,
  output exec_pkg::alu_req_t                lane_req,
  input  logic [exec_pkg::num_lanes-1:0]    lane_ready
);

  // next lane to receive a request
  logic [exec_pkg::lane_idx_w-1:0] issue_ptr;
  logic                            accept;

  // payload is broadcast, only the valid is steered
  assign lane_req = in_req;

  always_comb begin
    for (int i = 0; i < exec_pkg::num_lanes; i++) begin
      lane_valid[i] = in_valid && !flush &&
                      (issue_ptr == exec_pkg::lane_idx_w'(i));
    end
  end

  // never skip a busy lane, order depends on it
  assign in_ready = lane_ready[issue_ptr] && !flush;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      issue_ptr <= '0;
    end else if (accept) begin
      issue_ptr <= exec_pkg::next_lane(issue_ptr);
    end
  end

  // at most one lane is offered a request
  lane_valid_onehot_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(lane_valid)
  ) else $error("dispatcher drives more than one lane valid");

endmodule

`default_nettype wire

/* hw/alu_lane.sv */
// two-stage ALU lane: operand register, then result register, valid/ready on both sides
`timescale 1ns/1ps
`default_nettype none

module alu_lane (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush,

  input  logic                in_valid,
  input  exec_pkg::alu_req_t  in_req,
  output logic                in_ready,

  output logic                out_valid,
  output exec_pkg::wb_t       out_wb,
  input  logic                out_ready
);

  // stage one, operands
  logic               s1_valid;
  exec_pkg::alu_req_t s1_req;
  logic               s1_ready;

  // stage two, writeback
  logic               s2_valid;
  exec_pkg::wb_t      s2_wb;
  logic               s2_ready;

  logic [exec_pkg::xlen-1:0]    alu_result;
  logic [exec_pkg::shamt_w-1:0] shamt;

  // a stage moves when the next one is empty or draining
  assign s2_ready = !s2_valid || out_ready;
  assign s1_ready = !s1_valid || s2_ready;
  assign in_ready = s1_ready;

  assign shamt = s1_req.rs2_val[exec_pkg::shamt_w-1:0];

  always_comb begin
    case (s1_req.op)
      exec_pkg::op_add:  alu_result = s1_req.rs1_val + s1_req.rs2_val;
      exec_pkg::op_sub:  alu_result = s1_req.rs1_val - s1_req.rs2_val;
      exec_pkg::op_and:  alu_result = s1_req.rs1_val & s1_req.rs2_val;
      exec_pkg::op_or:   alu_result = s1_req.rs1_val | s1_req.rs2_val;
      exec_pkg::op_xor:  alu_result = s1_req.rs1_val ^ s1_req.rs2_val;
      exec_pkg::op_sll:  alu_result = s1_req.rs1_val << shamt;
      exec_pkg::op_srl:  alu_result = s1_req.rs1_val >> shamt;
      exec_pkg::op_sra:  alu_result = $unsigned($signed(s1_req.rs1_val) >>> shamt);
      exec_pkg::op_slt:
        alu_result = exec_pkg::xlen'($signed(s1_req.rs1_val) < $signed(s1_req.rs2_val));
      exec_pkg::op_sltu:
        alu_result = exec_pkg::xlen'(s1_req.rs1_val < s1_req.rs2_val);
      default:           alu_result = '0;
    endcase
  end

  // control
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid <= in_valid;
      end
      if (s2_ready) begin
        s2_valid <= s1_valid;
      end
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (in_valid && s1_ready) begin
      s1_req <= in_req;
    end
    if (s1_valid && s2_ready) begin
      s2_wb.rd     <= s1_req.rd;
      s2_wb.result <= alu_result;
    end
  end

  assign out_valid = s2_valid;
  assign out_wb    = s2_wb;

  // a stalled result is held until taken
  out_hold_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_wb))
  ) else $error("lane output changed while stalled");

  flush_clears_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    flush |=> (!s1_valid && !s2_valid)
  ) else $error("lane still holds an op after flush");

endmodule

`default_nettype wire

/* hw/in_order_committer.sv */
// drains the ALU lanes round-robin so writebacks leave in program order
`timescale 1ns/1ps
`default_nettype none

module in_order_committer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush,

  input  logic [exec_pkg::num_lanes-1:0]    lane_valid,
  input  exec_pkg::wb_t                     lane_wb [exec_pkg::num_lanes],
  output logic [exec_pkg::num_lanes-1:0]    lane_ready,

  output logic                              out_valid,
  output exec_pkg::wb_t                     out_wb,
  input  logic                              out_ready
);

  // lane holding the oldest result
  logic [exec_pkg::lane_idx_w-1:0] drain_ptr;
  logic                            commit;

  // later lanes may be done already, they wait their turn
  assign out_valid = lane_valid[drain_ptr] && !flush;
  assign out_wb    = lane_wb[drain_ptr];
  assign commit    = out_valid && out_ready;

  always_comb begin
    for (int i = 0; i < exec_pkg::num_lanes; i++) begin
      lane_ready[i] = out_ready && !flush &&
                      (drain_ptr == exec_pkg::lane_idx_w'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      drain_ptr <= '0;
    end else if (commit) begin
      drain_ptr <= exec_pkg::next_lane(drain_ptr);
    end
  end

  lane_ready_onehot_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(lane_ready)
  ) else $error("committer returns ready to more than one lane");

  // a waiting writeback stays offered until committed
  out_hold_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready && !flush) |=> (out_valid && $stable(out_wb))
  ) else $error("committer output dropped or changed while stalled");

endmodule

`default_nettype wire

/* hw/exec_cluster.sv */
// integer execute cluster top: dispatcher, a bank of ALU lanes and the in-order committer
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush,

  input  logic                in_valid,
  input  exec_pkg::alu_req_t  in_req,
  output logic                in_ready,

  output logic                out_valid,
  output exec_pkg::wb_t       out_wb,
  input  logic                out_ready
);

  // dispatcher to lanes
  logic [exec_pkg::num_lanes-1:0] lane_in_valid;
  logic [exec_pkg::num_lanes-1:0] lane_in_ready;
  exec_pkg::alu_req_t             lane_req;

  // lanes to committer
  logic [exec_pkg::num_lanes-1:0] lane_out_valid;
  logic [exec_pkg::num_lanes-1:0] lane_out_ready;
  exec_pkg::wb_t                  lane_wb [exec_pkg::num_lanes];

  alu_dispatcher dispatcher_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .in_ready   (in_ready),
    .lane_valid (lane_in_valid),
    .lane_req   (lane_req),
    .lane_ready (lane_in_ready)
  );

  for (genvar i = 0; i < exec_pkg::num_lanes; i++) begin : lane_g
    alu_lane lane_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .in_valid  (lane_in_valid[i]),
      .in_req    (lane_req),
      .in_ready  (lane_in_ready[i]),
      .out_valid (lane_out_valid[i]),
      .out_wb    (lane_wb[i]),
      .out_ready (lane_out_ready[i])
    );
  end

  in_order_committer committer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .lane_valid (lane_out_valid),
    .lane_wb    (lane_wb),
    .lane_ready (lane_out_ready),
    .out_valid  (out_valid),
    .out_wb     (out_wb),
    .out_ready  (out_ready)
  );

endmodule

`default_nettype wire

/* tb/exec_cluster_tb.sv */
// self-checking testbench for the execute cluster, compiled with the package and RTL from src.f
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb;

  localparam int          num_rows       = 40;
  localparam int          n_burst        = 20;
  localparam int          flush_row      = 30;
  localparam int          timeout_cycles = 8 * num_rows + 50;
  localparam logic [31:0] lfsr_seed      = 32'h63d47cdb;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] lfsr_taps      = 32'h80200003;

  // one stimulus row with its expected writeback
  typedef struct packed {
    exec_pkg::alu_op_e                op;
    logic [exec_pkg::xlen-1:0]        rs1;
    logic [exec_pkg::xlen-1:0]        rs2;
    logic [exec_pkg::reg_addr_w-1:0]  rd;
    logic                             flush;
    exec_pkg::wb_t                    exp;
  } row_t;

  logic               clk;
  logic               rst_n;
  logic               flush;
  logic               in_valid;
  exec_pkg::alu_req_t in_req;
  logic               in_ready;
  logic               out_valid;
  exec_pkg::wb_t      out_wb;
  logic               out_ready;

  row_t          stim [num_rows];
  int            n_rows;
  exec_pkg::wb_t exp_q [$];
  logic [31:0]   lfsr;

  int   mismatch_count = 0;
  int   other_count    = 0;
  int   cycle_count    = 0;
  int   acc_idx        = 0;
  int   out_count      = 0;
  int   first_acc_cyc  = 0;
  int   first_out_cyc  = 0;
  int   last_out_cyc   = 0;
  logic rst_q          = 1'b1;

  exec_cluster dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_wb    (out_wb),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ lfsr_taps;
    end
    return n;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic logic [31:0] ref_alu(input exec_pkg::alu_op_e op,
                                          input logic [31:0] a,
                                          input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] r;
    sh = b[4:0];
    case (op)
      exec_pkg::op_add:  r = a + b;
      exec_pkg::op_sub:  r = a + ~b + 32'd1;
      exec_pkg::op_and:  r = a & b;
      exec_pkg::op_or:   r = a | b;
      exec_pkg::op_xor:  r = a ^ b;
      exec_pkg::op_sll:  r = a << sh;
      exec_pkg::op_srl:  r = a >> sh;
      // logical shift, then refill the vacated top bits with the sign
      exec_pkg::op_sra:  r = (a >> sh) | ({32{a[31]}} & ~(32'hffffffff >> sh));
      // differing signs decide alone
      exec_pkg::op_slt:  r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      exec_pkg::op_sltu: r = {31'd0, a < b};
      default:           r = '0;
    endcase
    return r;
  endfunction

  task automatic add_row(input exec_pkg::alu_op_e op, input logic [31:0] a,
                         input logic [31:0] b, input logic [4:0] rd,
                         input logic fl, input logic [31:0] res);
    row_t r;
    r.op         = op;
    r.rs1        = a;
    r.rs2        = b;
    r.rd         = rd;
    r.flush      = fl;
    r.exp.rd     = rd;
    r.exp.result = res;
    stim[n_rows] = r;
    n_rows++;
  endtask

  task automatic build_table();
    exec_pkg::alu_op_e op;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [4:0]        rd;
    n_rows = 0;
    // corner operands, results worked out by hand
    add_row(exec_pkg::op_add,  32'hffffffff, 32'h00000001, 5'd1,  1'b0, 32'h00000000);
    add_row(exec_pkg::op_sub,  32'h00000000, 32'h00000001, 5'd2,  1'b0, 32'hffffffff);
    add_row(exec_pkg::op_and,  32'hffffffff, 32'h80000000, 5'd3,  1'b0, 32'h80000000);
    add_row(exec_pkg::op_or,   32'h80000000, 32'h00000000, 5'd4,  1'b0, 32'h80000000);
    add_row(exec_pkg::op_xor,  32'hffffffff, 32'h80000000, 5'd5,  1'b0, 32'h7fffffff);
    add_row(exec_pkg::op_sll,  32'h00000001, 32'h0000001f, 5'd6,  1'b0, 32'h80000000);
    add_row(exec_pkg::op_sll,  32'hffffffff, 32'h00000000, 5'd7,  1'b0, 32'hffffffff);
    add_row(exec_pkg::op_srl,  32'h80000000, 32'h0000001f, 5'd8,  1'b0, 32'h00000001);
    add_row(exec_pkg::op_sra,  32'h80000000, 32'h0000001f, 5'd9,  1'b0, 32'hffffffff);
    add_row(exec_pkg::op_sra,  32'h80000000, 32'h00000000, 5'd10, 1'b0, 32'h80000000);
    // only the low 5 bits of rs2 count
    add_row(exec_pkg::op_sra,  32'h80000000, 32'hffffffe4, 5'd11, 1'b0, 32'hf8000000);
    add_row(exec_pkg::op_srl,  32'hffffffff, 32'h00000023, 5'd12, 1'b0, 32'h1fffffff);
    add_row(exec_pkg::op_sll,  32'h00000001, 32'h00000020, 5'd17, 1'b0, 32'h00000001);
    add_row(exec_pkg::op_slt,  32'h80000000, 32'h00000000, 5'd13, 1'b0, 32'h00000001);
    add_row(exec_pkg::op_sltu, 32'h80000000, 32'h00000000, 5'd14, 1'b0, 32'h00000000);
    add_row(exec_pkg::op_slt,  32'hffffffff, 32'h00000001, 5'd15, 1'b0, 32'h00000001);
    add_row(exec_pkg::op_sltu, 32'hffffffff, 32'h00000001, 5'd16, 1'b0, 32'h00000000);
    add_row(exec_pkg::op_sub,  32'h80000000, 32'h00000001, 5'd18, 1'b0, 32'h7fffffff);
    add_row(exec_pkg::op_slt,  32'h7fffffff, 32'h80000000, 5'd19, 1'b0, 32'h00000000);
    add_row(exec_pkg::op_sltu, 32'h7fffffff, 32'h80000000, 5'd0,  1'b0, 32'h00000001);
    // random operands, every opcode twice
    for (int k = 0; k < num_rows - n_burst; k++) begin
      op = exec_pkg::alu_op_e'(k % 10);
      a  = take_bits(32);
      b  = take_bits(32);
      rd = 5'(take_bits(5));
      add_row(op, a, b, rd, (n_rows == flush_row), ref_alu(op, a, b));
    end
  endtask

  // offer one request and hold it until the cluster takes it
  task automatic send_row(input row_t r, input logic rand_ready);
    in_valid       <= 1'b1;
    in_req.op      <= r.op;
    in_req.rs1_val <= r.rs1;
    in_req.rs2_val <= r.rs2;
    in_req.rd      <= r.rd;
    // a flush row pulses flush while its own request is already offered
    flush          <= r.flush;
    do begin
      @(posedge clk);
      flush <= 1'b0;
      if (rand_ready) begin
        // stall on about one cycle in four
        out_ready <= (take_bits(2) != 32'd0);
      end
    end while (!(in_valid && in_ready));
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  always @(posedge clk) begin : scoreboard
    exec_pkg::wb_t exp_wb;
    cycle_count++;
    // out_valid stays low through reset and the cycle after it
    if (!rst_q) begin
      assert (out_valid === 1'b0) else begin
        other_count++;
        $display("out_valid was high at %0d ns during or right after reset", $time);
      end
      // the first request is taken right after reset
      if (rst_n) begin
        assert (in_ready === 1'b1) else begin
          other_count++;
          $display("in_ready was low at %0d ns in the first cycle after reset", $time);
        end
      end
    end
    rst_q = rst_n;
    if (rst_n && out_valid && out_ready) begin
      assert (exp_q.size() != 0) else begin
        other_count++;
        $display("unexpected output at %0d ns: rd %0d result %h",
                 $time, out_wb.rd, out_wb.result);
      end
      if (exp_q.size() != 0) begin
        exp_wb = exp_q.pop_front();
        assert (out_wb === exp_wb) else begin
          mismatch_count++;
          $display("Mismatch at %0d ns: expected rd %0d result %h, got rd %0d result %h",
                   $time, exp_wb.rd, exp_wb.result, out_wb.rd, out_wb.result);
        end
      end
      if (out_count == 0) begin
        first_out_cyc = cycle_count;
      end
      last_out_cyc = cycle_count;
      out_count++;
    end
    // everything in flight is dropped
    if (rst_n && flush) begin
      assert (!(in_valid && in_ready)) else begin
        other_count++;
        $display("request accepted during flush at %0d ns", $time);
      end
      exp_q.delete();
    end
    if (rst_n && in_valid && in_ready) begin
      if (acc_idx == 0) begin
        first_acc_cyc = cycle_count;
      end
      exp_q.push_back(stim[acc_idx].exp);
      acc_idx++;
    end
  end

  initial begin : watchdog
    while (cycle_count < timeout_cycles) begin
      @(negedge clk);
    end
    other_count++;
    $display("timeout: outputs still missing after %0d cycles", timeout_cycles);
    finish_run();
  end

  initial begin : main
    rst_n     = 1'b0;
    flush     = 1'b0;
    in_valid  = 1'b0;
    in_req    = '0;
    out_ready = 1'b1;
    lfsr      = lfsr_seed;
    build_table();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // back-to-back burst with the output always ready
    for (int i = 0; i < n_burst; i++) begin
      send_row(stim[i], 1'b0);
    end
    in_valid <= 1'b0;
    do @(negedge clk); while (out_count < n_burst);
    assert (first_out_cyc - first_acc_cyc == 2) else begin
      other_count++;
      $display("first result came %0d cycles after the first accept, not 2",
               first_out_cyc - first_acc_cyc);
    end
    assert (last_out_cyc - first_out_cyc == n_burst - 1) else begin
      other_count++;
      $display("burst results did not leave one per cycle");
    end
    // random back-pressure with one flush in between
    @(posedge clk);
    for (int i = n_burst; i < num_rows; i++) begin
      send_row(stim[i], 1'b1);
    end
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    do @(negedge clk); while (exp_q.size() != 0);
    // give a stray extra output time to show up
    repeat (4) @(negedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

/* src.f */
hw/exec_pkg.sv
hw/alu_dispatcher.sv
hw/alu_lane.sv
hw/in_order_committer.sv
hw/exec_cluster.sv
tb/exec_cluster_tb.sv

/* Bender.yml */
package:
  name: exec_cluster

sources:
  - hw/exec_pkg.sv
  - hw/alu_dispatcher.sv
  - hw/alu_lane.sv
  - hw/in_order_committer.sv
  - hw/exec_cluster.sv
  - target: simulation
    files:
      - tb/exec_cluster_tb.sv
